//--- src.f
+incdir+bench
design/rv1Pkg.sv
design/rv1Decoder.sv
design/rv1RegFile.sv
design/rv1Alu.sv
design/rv1ImmTarget.sv
design/rv1Core.sv
bench/rv1Tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module rv1Tb -f src.f -o rv1Sim \
    && ./obj_dir/rv1Sim | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- bench/rv1RefModel.svh
`ifndef RV1_REF_MODEL_SVH
`define RV1_REF_MODEL_SVH

// instruction set model with its own pc, registers and RAM
logic [31:0] refPc;
logic [31:0] refRegs [32];
logic [31:0] refRam [64];

function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic [31:0] sra;
    sa = a;
    sra = sa >>> b[4:0];
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: return alt ? sra : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// retires one instruction, reports any store or load it makes
task automatic refStep(output bit stored, output logic [31:0] stAddr,
                       output logic [31:0] stData, output bit loaded,
                       output logic [31:0] ldAddr);
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] result;
    logic [31:0] nextPc;
    logic [2:0] f3;
    logic [6:0] f7;
    bit writes;
    inst = progRom[refPc[7:2]];
    f3 = inst[14:12];
    f7 = inst[31:25];
    a = refRegs[inst[19:15]];
    b = refRegs[inst[24:20]];
    immI = {{20{inst[31]}}, inst[31:20]};
    nextPc = refPc + 32'd4;
    result = refPc + 32'd4;
    writes = 1'b0;
    stored = 1'b0;
    stAddr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
    stData = b;
    loaded = 1'b0;
    ldAddr = a + immI;
    case (inst[6:0])
        OP: begin
            writes = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            result = refAlu(f3, f7 == 7'h20, a, b);
        end
        OPIMM: begin
            // shift immediates carry funct7 in the upper bits
            writes = (f3 == 3'd1) ? (f7 == 7'h00) :
                     (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
            result = refAlu(f3, f3 == 3'd5 && f7 == 7'h20, a, immI);
        end
        LUI: begin
            writes = 1'b1;
            result = {inst[31:12], 12'b0};
        end
        AUIPC: begin
            writes = 1'b1;
            result = refPc + {inst[31:12], 12'b0};
        end
        LOAD: begin
            loaded = (f3 == 3'd2);
            writes = loaded;
            result = refRam[ldAddr[7:2]];
        end
        STORE: begin
            stored = (f3 == 3'd2);
        end
        BRANCH: begin
            if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                nextPc = refPc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                  inst[11:8], 1'b0};
            end
        end
        JAL: begin
            writes = 1'b1;
            nextPc = refPc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                              inst[30:21], 1'b0};
        end
        JALR: begin
            writes = (f3 == 3'd0);
            nextPc = (f3 == 3'd0) ? ((a + immI) & ~32'd1) : nextPc;
        end
        default: begin
            writes = 1'b0;
        end
    endcase
    if (stored) begin
        refRam[stAddr[7:2]] = stData;
    end
    if (writes && inst[11:7] != 5'd0) begin
        refRegs[inst[11:7]] = result;
    end
    refPc = nextPc;
endtask

`endif

//--- bench/rv1Tb.sv
`default_nettype none

module rv1Tb import rv1Pkg::*; ();

    localparam int PROG_LEN = 64;
    localparam int HALT_INDEX = PROG_LEN - 1;
    localparam int TIMEOUT_CYCLES = 2 * PROG_LEN + 20;

    logic clk = 1'b0;
    logic rst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instruction;
    logic [XLEN-1:0] dataAddr;
    logic memReadEnable;
    logic memWriteEnable;
    logic [XLEN-1:0] writeData;
    logic [XLEN-1:0] readData;
    logic [4:0] debugAddr;
    logic [XLEN-1:0] debugData;
    logic [31:0] progRom [PROG_LEN];
    logic [31:0] dataRam [64];
    bit isTarget [PROG_LEN];
    int errorCount = 0;
    int timeoutCount = 0;

    `include "rv1RefModel.svh"

    rv1Core dut_i (.*);

    always #2 clk = ~clk;

    // ROM and RAM answer combinationally, RAM writes on the edge
    assign instruction = progRom[pc[7:2]];
    assign readData = dataRam[dataAddr[7:2]];

    always @(posedge clk) begin
        if (memWriteEnable) begin
            dataRam[dataAddr[7:2]] <= writeData;
        end
    end

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        errorCount++;
        $display("error %s: got %h, expected %h", name, got, expected);
    endtask

    task automatic finishRun();
        $display("value errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    function automatic logic [4:0] randReg();
        return 5'($urandom_range(15));
    endfunction

    // forward only, at most eight slots ahead
    function automatic int pickTarget(input int from);
        int t;
        t = from + 1 + int'($urandom_range(7));
        t = (t > HALT_INDEX) ? HALT_INDEX : t;
        isTarget[t] = 1'b1;
        return t;
    endfunction

    task automatic buildProgram();
        logic [2:0] f3;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [11:0] imm;
        int t;
        int i;
        for (int r = 1; r <= 8; r++) begin
            progRom[2*r-2] = {20'($urandom), 5'(r), LUI};
            progRom[2*r-1] = {12'($urandom), 5'(r), 3'b000, 5'(r), OPIMM};
        end
        i = 16;
        while (i < HALT_INDEX) begin
            f3 = 3'($urandom_range(7));
            rd = randReg();
            rs1 = randReg();
            imm = 12'($urandom);
            case ($urandom_range(9))
                0, 1: progRom[i] = {((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00,
                                    randReg(), rs1, f3, rd, OP};
                2, 3: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm[11:5] = (f3 == 3'd5 && imm[11]) ? 7'h20 : 7'h00;
                    end
                    progRom[i] = {imm, rs1, f3, rd, OPIMM};
                end
                4: progRom[i] = {20'($urandom), rd, imm[0] ? LUI : AUIPC};
                5: progRom[i] = {4'b0000, imm[5:0], 2'b00, 5'd0, 3'b010, rd, LOAD};
                6: progRom[i] = {4'b0000, imm[5:3], randReg(), 5'd0, 3'b010, imm[2:0], 2'b00,
                                 STORE};
                7: begin
                    t = (pickTarget(i) - i) * 4;
                    progRom[i] = {t[12], t[10:5], imm[0] ? rs1 : randReg(), rs1, 2'b00, imm[1],
                                  t[4:1], t[11], BRANCH};
                end
                8: begin
                    t = (pickTarget(i) - i) * 4;
                    progRom[i] = {t[20], t[10:1], t[11], t[19:12], rd, JAL};
                end
                default: begin
                    // jal links x31 to the next slot, jalr then jumps forward from it
                    if (i + 1 < HALT_INDEX && !isTarget[i + 1]) begin
                        t = (pickTarget(i + 1) - i - 1) * 4;
                        progRom[i] = {1'b0, 10'd2, 1'b0, 8'd0, 5'd31, JAL};
                        progRom[i + 1] = {t[11:0], 5'd31, 3'b000, rd, JALR};
                        i++;
                    end else begin
                        progRom[i] = {12'd0, 5'd0, 3'b000, 5'd0, OPIMM};
                    end
                end
            endcase
            i++;
        end
        // jal to itself
        progRom[HALT_INDEX] = {20'd0, 5'd0, JAL};
    endtask

    initial begin
        bit stored;
        logic [31:0] stAddr;
        logic [31:0] stData;
        bit loaded;
        logic [31:0] ldAddr;
        logic [31:0] firstInst;
        rst = 1'b1;
        debugAddr = 5'd0;
        void'($urandom(18));
        buildProgram();
        for (int w = 0; w < 64; w++) begin
            dataRam[w] = 32'h9e3779b9 * (w + 1);
            refRam[w] = dataRam[w];
            refRegs[w % 32] = '0;
        end
        refPc = RESET_PC;
        // a store at the reset pc must not reach the RAM while rst is high
        firstInst = progRom[0];
        progRom[0] = {7'd0, 5'd1, 5'd0, 3'b010, 5'd0, STORE};
        repeat (3) begin
            @(posedge clk);
            #1;
            assert (pc == RESET_PC) else reportValue("pc", pc, RESET_PC);
            assert (!memWriteEnable) else reportValue("memWriteEnable", 32'(memWriteEnable), 0);
        end
        progRom[0] = firstInst;
        rst = 1'b0;
        while (refPc != HALT_INDEX * 4) begin
            @(negedge clk);
            assert (pc == refPc) else reportValue("pc", pc, refPc);
            refStep(stored, stAddr, stData, loaded, ldAddr);
            assert (memWriteEnable == stored)
                else reportValue("memWriteEnable", 32'(memWriteEnable), 32'(stored));
            assert (memReadEnable == loaded)
                else reportValue("memReadEnable", 32'(memReadEnable), 32'(loaded));
            if (stored) begin
                assert (dataAddr == stAddr) else reportValue("dataAddr", dataAddr, stAddr);
                assert (writeData == stData) else reportValue("writeData", writeData, stData);
            end
            if (loaded) begin
                assert (dataAddr == ldAddr) else reportValue("dataAddr", dataAddr, ldAddr);
            end
        end
        // core sits on the halt jump while the registers are read out
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1;
            debugAddr = 5'(r);
            @(negedge clk);
            assert (pc == refPc) else reportValue("pc", pc, refPc);
            assert (debugData == refRegs[r]) else reportValue("debugData", debugData, refRegs[r]);
        end
        finishRun();
    end

    initial begin
        int cycleCount;
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the program did not reach its halt within %0d cycles", TIMEOUT_CYCLES);
        timeoutCount++;
        finishRun();
    end

endmodule

`default_nettype wire

//--- design/rv1Core.sv
`default_nettype none

module rv1Core import rv1Pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst,
    // instruction ROM
    output logic [XLEN-1:0]      pc,
    input  wire logic [XLEN-1:0] instruction,
    // data RAM
    output logic [XLEN-1:0]      dataAddr,
    output logic                 memReadEnable,
    output logic                 memWriteEnable,
    output logic [XLEN-1:0]      writeData,
    input  wire logic [XLEN-1:0] readData,
    // register debug port
    input  wire logic [4:0]      debugAddr,
    output logic [XLEN-1:0]      debugData
);

    ctrlT            ctrl;
    immT             imm;
    logic            branchEqual;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] nextPc;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] aluLeft;
    logic [XLEN-1:0] aluRight;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] wbData;
    logic            regWriteEnable;

    // pc register and next-pc select
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.pcSel)
            PC_BRANCH:  nextPc = imm.branchTarget;
            PC_JUMP:    nextPc = imm.jumpTarget;
            PC_JUMPREG: nextPc = imm.jumpRegTarget;
            default:    nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    rv1Decoder decoderInst (
        .instruction(instruction),
        .branchEqual(branchEqual),
        .ctrl(ctrl)
    );

    rv1ImmTarget immTargetInst (
        .instruction(instruction),
        .pc(pc),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .immFmt(ctrl.immFmt),
        .imm(imm),
        .branchEqual(branchEqual)
    );

    rv1RegFile regFileInst (
        .clk(clk),
        .rst(rst),
        .readAddr1(instruction[19:15]),
        .readAddr2(instruction[24:20]),
        .writeAddr(instruction[11:7]),
        .writeData(wbData),
        .writeEnable(regWriteEnable),
        .readData1(rs1Data),
        .readData2(rs2Data),
        .debugAddr(debugAddr),
        .debugData(debugData)
    );

    // operand select, pc on the left only for auipc
    assign aluLeft  = (ctrl.op1Sel == OP1_PC) ? pc : rs1Data;
    assign aluRight = (ctrl.op2Sel == OP2_IMM) ? imm.value : rs2Data;

    rv1Alu aluInst (
        .aluOp(ctrl.aluOp),
        .leftOperand(aluLeft),
        .rightOperand(aluRight),
        .result(aluResult)
    );

    always_comb begin
        case (ctrl.wbSel)
            WB_MEM:  wbData = readData;
            WB_PC4:  wbData = pcPlus4;
            WB_IMM:  wbData = imm.value;
            default: wbData = aluResult;
        endcase
    end

    // nothing gets written while in reset
    assign regWriteEnable = ctrl.regWriteEnable && !rst;
    assign memReadEnable  = ctrl.memReadEnable && !rst;
    assign memWriteEnable = ctrl.memWriteEnable && !rst;

    assign dataAddr  = aluResult;
    assign writeData = rs2Data;

    // every target the core can take keeps the pc on a word boundary
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc misaligned: %h", pc);

endmodule

`default_nettype wire

//--- design/rv1ImmTarget.sv
`default_nettype none

module rv1ImmTarget import rv1Pkg::*; (
    input  wire logic [XLEN-1:0] instruction,
    input  wire logic [XLEN-1:0] pc,
    input  wire logic [XLEN-1:0] rs1Data,
    input  wire logic [XLEN-1:0] rs2Data,
    input  wire immFmtT          immFmt,
    output immT                  imm,
    output logic                 branchEqual
);

    logic [XLEN-1:0] iImm;
    logic [XLEN-1:0] sImm;
    logic [XLEN-1:0] bImm;
    logic [XLEN-1:0] uImm;
    logic [XLEN-1:0] jImm;
    logic [XLEN-1:0] selectedImm;
    logic [XLEN-1:0] jumpRegSum;

    // sign bit is always instruction[31]
    assign iImm = {{20{instruction[31]}}, instruction[31:20]};
    assign sImm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign bImm = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign uImm = {instruction[31:12], 12'b0};
    assign jImm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        case (immFmt)
            IMM_S:   selectedImm = sImm;
            IMM_U:   selectedImm = uImm;
            IMM_B:   selectedImm = bImm;
            IMM_J:   selectedImm = jImm;
            default: selectedImm = iImm;
        endcase
    end

    // jalr drops bit zero of the sum
    assign jumpRegSum = rs1Data + iImm;

    assign imm = '{
        value:         selectedImm,
        branchTarget:  pc + bImm,
        jumpTarget:    pc + jImm,
        jumpRegTarget: {jumpRegSum[XLEN-1:1], 1'b0}
    };

    // kept apart from the immediate path, the decoder reads it back
    assign branchEqual = (rs1Data == rs2Data);

endmodule

`default_nettype wire

//--- design/rv1Alu.sv
`default_nettype none

module rv1Alu import rv1Pkg::*; (
    input  wire aluOpT           aluOp,
    input  wire logic [XLEN-1:0] leftOperand,
    input  wire logic [XLEN-1:0] rightOperand,
    output logic [XLEN-1:0]      result
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    // only the low five bits count for shifts
    assign shamt = rightOperand[4:0];

    assign lessSigned   = $signed(leftOperand) < $signed(rightOperand);
    assign lessUnsigned = leftOperand < rightOperand;

    always_comb begin
        case (aluOp)
            ALU_ADD: begin
                result = leftOperand + rightOperand;
            end
            ALU_SUB: begin
                result = leftOperand - rightOperand;
            end
            ALU_AND: begin
                result = leftOperand & rightOperand;
            end
            ALU_OR: begin
                result = leftOperand | rightOperand;
            end
            ALU_XOR: begin
                result = leftOperand ^ rightOperand;
            end
            ALU_SLL: begin
                result = leftOperand << shamt;
            end
            ALU_SRL: begin
                result = leftOperand >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(leftOperand) >>> shamt);
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, lessSigned};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, lessUnsigned};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv1RegFile.sv
`default_nettype none

module rv1RegFile import rv1Pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic [4:0]      readAddr1,
    input  wire logic [4:0]      readAddr2,
    input  wire logic [4:0]      writeAddr,
    input  wire logic [XLEN-1:0] writeData,
    input  wire logic            writeEnable,
    output logic [XLEN-1:0]      readData1,
    output logic [XLEN-1:0]      readData2,
    input  wire logic [4:0]      debugAddr,
    output logic [XLEN-1:0]      debugData
);

    // x0 keeps a slot that reset clears and writes skip
    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // reads are combinational, a write shows up next cycle
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];
    assign debugData = regs[debugAddr];

    // x0 stays zero on all three ports, across any writes aimed at it
    assert property (@(posedge clk) disable iff (rst)
        (readAddr1 != 5'd0 || readData1 == '0) &&
        (readAddr2 != 5'd0 || readData2 == '0) &&
        (debugAddr != 5'd0 || debugData == '0))
        else $error("x0 read nonzero: %h %h %h", readData1, readData2, debugData);

endmodule

`default_nettype wire

//--- design/rv1Decoder.sv
`default_nettype none

module rv1Decoder import rv1Pkg::*; (
    input  wire logic [XLEN-1:0] instruction,
    input  wire logic            branchEqual,
    output ctrlT                 ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       opValid;
    logic       opImmValid;
    logic       branchTaken;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // shared by OP and OP-IMM, alt picks SUB or SRA
    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic alt);
        aluOpT op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // alternate funct7 only legal for sub and sra
    assign opValid = (funct7 == F7_BASE) ||
                     ((funct7 == F7_ALT) && (funct3 == F3_ADD || funct3 == F3_SR));

    // immediates free except on shifts, where the upper bits are funct7
    assign opImmValid = (funct3 == F3_SLL) ? (funct7 == F7_BASE) :
                        (funct3 == F3_SR)  ? (funct7 == F7_BASE || funct7 == F7_ALT) :
                        1'b1;

    assign branchTaken = ((funct3 == F3_BEQ) && branchEqual) ||
                         ((funct3 == F3_BNE) && !branchEqual);

    always_comb begin
        ctrl = CTRL_NOP;
        case (opcode)
            OP: begin
                if (opValid) begin
                    ctrl.aluOp = aluFromFunct3(funct3, funct7 == F7_ALT);
                    ctrl.regWriteEnable = 1'b1;
                end
            end
            OPIMM: begin
                if (opImmValid) begin
                    ctrl.aluOp = aluFromFunct3(funct3, funct3 == F3_SR && funct7 == F7_ALT);
                    ctrl.op2Sel = OP2_IMM;
                    ctrl.regWriteEnable = 1'b1;
                end
            end
            LUI: begin
                ctrl.immFmt = IMM_U;
                ctrl.wbSel = WB_IMM;
                ctrl.regWriteEnable = 1'b1;
            end
            AUIPC: begin
                ctrl.immFmt = IMM_U;
                ctrl.op1Sel = OP1_PC;
                ctrl.op2Sel = OP2_IMM;
                ctrl.regWriteEnable = 1'b1;
            end
            LOAD: begin
                if (funct3 == F3_WORD) begin
                    ctrl.op2Sel = OP2_IMM;
                    ctrl.wbSel = WB_MEM;
                    ctrl.memReadEnable = 1'b1;
                    ctrl.regWriteEnable = 1'b1;
                end
            end
            STORE: begin
                if (funct3 == F3_WORD) begin
                    ctrl.immFmt = IMM_S;
                    ctrl.op2Sel = OP2_IMM;
                    ctrl.memWriteEnable = 1'b1;
                end
            end
            BRANCH: begin
                ctrl.immFmt = IMM_B;
                if (branchTaken) begin
                    ctrl.pcSel = PC_BRANCH;
                end
            end
            JAL: begin
                ctrl.immFmt = IMM_J;
                ctrl.pcSel = PC_JUMP;
                ctrl.wbSel = WB_PC4;
                ctrl.regWriteEnable = 1'b1;
            end
            JALR: begin
                if (funct3 == F3_JALR) begin
                    ctrl.pcSel = PC_JUMPREG;
                    ctrl.wbSel = WB_PC4;
                    ctrl.regWriteEnable = 1'b1;
                end
            end
            default: begin
                ctrl = CTRL_NOP;
            end
        endcase
    end

    // one data memory access per instruction at most
    always_comb begin
        assert (!(ctrl.memReadEnable && ctrl.memWriteEnable))
            else $error("memReadEnable and memWriteEnable both high, instruction %h",
                        instruction);
    end

endmodule

`default_nettype wire

//--- design/rv1Pkg.sv
`default_nettype none

package rv1Pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // major opcodes, instruction bits [6:0]
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OPIMM  = 7'b0010011;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for branches, word access and jalr
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_JALR = 3'b000;

    // funct7, the alternate form selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } aluOpT;

    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP, PC_JUMPREG} pcSelT;
    typedef enum logic {OP1_RS1, OP1_PC} op1SelT;
    typedef enum logic {OP2_RS2, OP2_IMM} op2SelT;

    // imm writeback carries the lui value past the ALU
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wbSelT;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_U, IMM_B, IMM_J} immFmtT;

    typedef struct packed {
        pcSelT  pcSel;
        op1SelT op1Sel;
        op2SelT op2Sel;
        aluOpT  aluOp;
        immFmtT immFmt;
        wbSelT  wbSel;
        logic   regWriteEnable;
        logic   memReadEnable;
        logic   memWriteEnable;
    } ctrlT;

    typedef struct packed {
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] branchTarget;
        logic [XLEN-1:0] jumpTarget;
        logic [XLEN-1:0] jumpRegTarget;
    } immT;

    // falls through to pc + 4 and writes nothing
    localparam ctrlT CTRL_NOP = '{
        pcSel: PC_PLUS4, op1Sel: OP1_RS1, op2Sel: OP2_RS2, aluOp: ALU_ADD,
        immFmt: IMM_I, wbSel: WB_ALU, regWriteEnable: 1'b0,
        memReadEnable: 1'b0, memWriteEnable: 1'b0
    };

endpackage

`default_nettype wire
